// File: hdl/rename_pkg.sv
`default_nettype none

package rename_pkg;

    localparam int num_log_regs  = 32;
    localparam int num_phys_regs = 64;
    localparam int log_idx_w     = $clog2(num_log_regs);
    localparam int phys_tag_w    = $clog2(num_phys_regs);
    localparam int free_depth    = num_phys_regs - num_log_regs;
    localparam int free_ptr_w    = $clog2(free_depth);
    localparam int free_cnt_w    = free_ptr_w + 1;           // holds 0..free_depth

    // rv32i major opcodes, bits 6..0 of the instruction word
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011
    } rv_opcode_e;

    typedef struct packed {
        rv_opcode_e             opcode;
        logic                   writes_rd;
        logic [log_idx_w-1:0]   rd_log;
        logic [phys_tag_w-1:0]  rd_tag;      // freshly allocated tag
        logic [phys_tag_w-1:0]  old_rd_tag;  // tag replaced in the map
        logic [phys_tag_w-1:0]  rs1_tag;
        logic                   rs1_ready;
        logic [phys_tag_w-1:0]  rs2_tag;
        logic                   rs2_ready;
    } renamed_uop_t;

    // branch and store have no rd, and x0 is never renamed
    function automatic logic instr_writes_rd(input logic [6:0] opc,
                                             input logic [log_idx_w-1:0] rd);
        logic no_rd;
        no_rd = (opc == opc_branch) || (opc == opc_store);
        return !no_rd && (rd != '0);
    endfunction

    function automatic logic instr_uses_rs1(input logic [6:0] opc);
        logic uses;
        case (opc)
            opc_lui, opc_auipc, opc_jal: uses = 1'b0;
            default:                     uses = 1'b1;
        endcase
        return uses;
    endfunction

    // unknown opcodes decode as op, so both sources count
    function automatic logic instr_uses_rs2(input logic [6:0] opc);
        logic uses;
        case (opc)
            opc_lui, opc_auipc, opc_jal,
            opc_jalr, opc_load, opc_op_imm: uses = 1'b0;
            default:                        uses = 1'b1;
        endcase
        return uses;
    endfunction

endpackage

`default_nettype wire

// File: hdl/reg_alias_table.sv
`timescale 1ns/10ps
`default_nettype none

module reg_alias_table
    import rename_pkg::*;
(
    input  wire logic                  id_on,
    input  wire logic                  reset,
    input  wire logic                  fire,
    input  wire logic [log_idx_w-1:0]  rs1_log,
    input  wire logic [log_idx_w-1:0]  rs2_log,
    input  wire logic [log_idx_w-1:0]  rd_log,
    input  wire logic                  writes_rd,
    input  wire logic [phys_tag_w-1:0] new_tag,
    input  wire logic                  wb_valid,
    input  wire logic [phys_tag_w-1:0] wb_tag,
    output logic      [phys_tag_w-1:0] rs1_tag,
    output logic      [phys_tag_w-1:0] rs2_tag,
    output logic      [phys_tag_w-1:0] old_rd_tag,
    output logic                       rs1_ready,
    output logic                       rs2_ready
);

    logic [phys_tag_w-1:0]    map_q [num_log_regs];
    logic [num_phys_regs-1:0] ready_q;

    logic remap;
    logic rs1_wb_hit;
    logic rs2_wb_hit;

    // x0 keeps physical tag 0 forever
    assign remap = fire && writes_rd && (rd_log != '0);

    // lookups read the map before this cycle's remap
    assign rs1_tag    = map_q[rs1_log];
    assign rs2_tag    = map_q[rs2_log];
    assign old_rd_tag = map_q[rd_log];

    // a writeback landing in the same cycle counts as ready already
    assign rs1_wb_hit = wb_valid && (wb_tag == rs1_tag);
    assign rs2_wb_hit = wb_valid && (wb_tag == rs2_tag);

    assign rs1_ready = ready_q[rs1_tag] || rs1_wb_hit;
    assign rs2_ready = ready_q[rs2_tag] || rs2_wb_hit;

    always_ff @(posedge id_on or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_log_regs; i++) begin
                map_q[i] <= phys_tag_w'(i);       // identity map
            end
        end else if (remap) begin
            map_q[rd_log] <= new_tag;
        end
    end

    // committed state is ready out of reset, free tags are not
    always_ff @(posedge id_on or posedge reset) begin
        if (reset) begin
            ready_q <= {{(num_phys_regs - num_log_regs){1'b0}}, {num_log_regs{1'b1}}};
        end else begin
            if (wb_valid) begin
                ready_q[wb_tag] <= 1'b1;
            end
            if (remap) begin
                ready_q[new_tag] <= 1'b0;         // new producer in flight
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/phys_free_list.sv
`timescale 1ns/10ps
`default_nettype none

module phys_free_list
    import rename_pkg::*;
(
    input  wire logic                  id_on,
    input  wire logic                  reset,
    input  wire logic                  pop,
    input  wire logic                  rel_valid,
    input  wire logic [phys_tag_w-1:0] rel_tag,
    output logic      [phys_tag_w-1:0] head_tag,
    output logic                       empty
);

    logic [phys_tag_w-1:0] queue_q [free_depth];
    logic [free_ptr_w-1:0] rd_ptr_q;
    logic [free_ptr_w-1:0] wr_ptr_q;
    logic [free_cnt_w-1:0] count_q;

    logic full;
    logic do_pop;
    logic do_push;

    assign empty = (count_q == '0);
    assign full  = (count_q == free_cnt_w'(free_depth));

    assign head_tag = queue_q[rd_ptr_q];

    // a push into a full queue only fits when a pop frees a slot
    assign do_pop  = pop && !empty;
    assign do_push = rel_valid && (!full || do_pop);

    always_ff @(posedge id_on or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < free_depth; i++) begin
                queue_q[i] <= phys_tag_w'(num_log_regs + i);   // tags 32..63
            end
        end else if (do_push) begin
            queue_q[wr_ptr_q] <= rel_tag;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge id_on or posedge reset) begin
        if (reset) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;                       // full, so wr meets rd
        end else begin
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge id_on or posedge reset) begin
        if (reset) begin
            count_q <= free_cnt_w'(free_depth);
        end else begin
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;      // idle or push with pop
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/rename_dispatch.sv
`timescale 1ns/10ps
`default_nettype none

module rename_dispatch
    import rename_pkg::*;
(
    input  wire logic                  id_on,
    input  wire logic                  reset,
    input  wire logic                  cyc,
    input  wire logic                  stb,
    input  wire logic                  we,
    input  wire logic [31:0]           dat_w,
    input  wire logic                  free_empty,
    input  wire logic [phys_tag_w-1:0] new_tag,
    input  wire logic [phys_tag_w-1:0] rs1_tag,
    input  wire logic [phys_tag_w-1:0] rs2_tag,
    input  wire logic [phys_tag_w-1:0] old_rd_tag,
    input  wire logic                  rs1_ready,
    input  wire logic                  rs2_ready,
    output logic                       ack,
    output logic                       fire,
    output logic                       alloc,
    output logic      [log_idx_w-1:0]  rs1_log,
    output logic      [log_idx_w-1:0]  rs2_log,
    output logic      [log_idx_w-1:0]  rd_log,
    output logic                       writes_rd,
    output logic                       uop_valid,
    output renamed_uop_t               uop
);

    logic [6:0]   opc;
    logic         uses_rs1;
    logic         uses_rs2;
    logic         request;
    renamed_uop_t uop_d;

    // instruction field slicing
    assign opc     = dat_w[6:0];
    assign rd_log  = dat_w[11:7];
    assign rs1_log = dat_w[19:15];
    assign rs2_log = dat_w[24:20];

    assign writes_rd = instr_writes_rd(opc, rd_log);
    assign uses_rs1  = instr_uses_rs1(opc);
    assign uses_rs2  = instr_uses_rs2(opc);

    // skip the cycle where ack is already up, the master still holds stb there
    assign request = cyc && stb && we && !ack;

    // writing instructions wait for a free tag, others pass straight through
    assign fire  = request && (!writes_rd || !free_empty);
    assign alloc = fire && writes_rd;

    always_comb begin
        uop_d            = '0;
        uop_d.opcode     = rv_opcode_e'(opc);
        uop_d.writes_rd  = writes_rd;
        uop_d.rd_log     = rd_log;
        uop_d.rd_tag     = writes_rd ? new_tag : '0;
        uop_d.old_rd_tag = writes_rd ? old_rd_tag : '0;
        uop_d.rs1_tag    = rs1_tag;
        uop_d.rs1_ready  = !uses_rs1 || rs1_ready;    // unused source never stalls
        uop_d.rs2_tag    = rs2_tag;
        uop_d.rs2_ready  = !uses_rs2 || rs2_ready;
    end

    // ack and uop_valid pulse together for one cycle
    always_ff @(posedge id_on or posedge reset) begin
        if (reset) begin
            ack       <= 1'b0;
            uop_valid <= 1'b0;
        end else begin
            ack       <= fire;
            uop_valid <= fire;
        end
    end

    always_ff @(posedge id_on) begin
        if (fire) begin
            uop <= uop_d;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rename_top.sv
`timescale 1ns/10ps
`default_nettype none

module rename_top
    import rename_pkg::*;
(
    input  wire logic                  id_on,
    input  wire logic                  reset,
    input  wire logic                  cyc,
    input  wire logic                  stb,
    input  wire logic                  we,
    input  wire logic [31:0]           dat_w,
    input  wire logic                  wb_valid,
    input  wire logic [phys_tag_w-1:0] wb_tag,
    input  wire logic                  rel_valid,
    input  wire logic [phys_tag_w-1:0] rel_tag,
    output logic                       ack,
    output logic                       uop_valid,
    output renamed_uop_t               uop
);

    logic                  fire;
    logic                  alloc;
    logic                  writes_rd;
    logic [log_idx_w-1:0]  rs1_log;
    logic [log_idx_w-1:0]  rs2_log;
    logic [log_idx_w-1:0]  rd_log;
    logic [phys_tag_w-1:0] head_tag;
    logic                  free_empty;
    logic [phys_tag_w-1:0] rs1_tag;
    logic [phys_tag_w-1:0] rs2_tag;
    logic [phys_tag_w-1:0] old_rd_tag;
    logic                  rs1_ready;
    logic                  rs2_ready;

    reg_alias_table reg_alias_table_i (
        .id_on      (id_on),
        .reset      (reset),
        .fire       (fire),
        .rs1_log    (rs1_log),
        .rs2_log    (rs2_log),
        .rd_log     (rd_log),
        .writes_rd  (writes_rd),
        .new_tag    (head_tag),
        .wb_valid   (wb_valid),
        .wb_tag     (wb_tag),
        .rs1_tag    (rs1_tag),
        .rs2_tag    (rs2_tag),
        .old_rd_tag (old_rd_tag),
        .rs1_ready  (rs1_ready),
        .rs2_ready  (rs2_ready)
    );

    phys_free_list phys_free_list_i (
        .id_on     (id_on),
        .reset     (reset),
        .pop       (alloc),                      // only writing instructions consume
        .rel_valid (rel_valid),
        .rel_tag   (rel_tag),
        .head_tag  (head_tag),
        .empty     (free_empty)
    );

    rename_dispatch rename_dispatch_i (
        .id_on      (id_on),
        .reset      (reset),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .dat_w      (dat_w),
        .free_empty (free_empty),
        .new_tag    (head_tag),
        .rs1_tag    (rs1_tag),
        .rs2_tag    (rs2_tag),
        .old_rd_tag (old_rd_tag),
        .rs1_ready  (rs1_ready),
        .rs2_ready  (rs2_ready),
        .ack        (ack),
        .fire       (fire),
        .alloc      (alloc),
        .rs1_log    (rs1_log),
        .rs2_log    (rs2_log),
        .rd_log     (rd_log),
        .writes_rd  (writes_rd),
        .uop_valid  (uop_valid),
        .uop        (uop)
    );

endmodule

`default_nettype wire

// File: sim/rename_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rename_tb
    import rename_pkg::*;
();

    localparam int ack_timeout  = 50;
    localparam int stall_cycles = 20;
    localparam int random_count = 300;

    logic                     id_on;
    logic                     reset;
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [31:0]              dat_w;
    logic                     wb_valid;
    logic [phys_tag_w-1:0]    wb_tag;
    logic                     rel_valid;
    logic [phys_tag_w-1:0]    rel_tag;
    logic                     ack;
    logic                     uop_valid;
    renamed_uop_t             uop;

    // reference model state
    logic [phys_tag_w-1:0]    model_map [num_log_regs];
    logic [num_phys_regs-1:0] model_ready;
    logic [phys_tag_w-1:0]    free_q [$];
    logic [phys_tag_w-1:0]    dead_q [$];       // replaced tags, candidates for release
    logic                     model_ack;
    renamed_uop_t             exp_uop;
    logic [6:0]               opc_table [10];

    rename_top rename_top_i (
        .id_on     (id_on),
        .reset     (reset),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .dat_w     (dat_w),
        .wb_valid  (wb_valid),
        .wb_tag    (wb_tag),
        .rel_valid (rel_valid),
        .rel_tag   (rel_tag),
        .ack       (ack),
        .uop_valid (uop_valid),
        .uop       (uop)
    );

    always #2 id_on = ~id_on;

    function automatic logic [31:0] make_instr(input logic [6:0] opc, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, opc};
    endfunction

    function automatic logic writes_dest(input logic [31:0] instr);
        logic [6:0] opc;
        opc = instr[6:0];
        return (opc != opc_branch) && (opc != opc_store) && (instr[11:7] != 5'd0);
    endfunction

    function automatic logic reads_rs1(input logic [6:0] opc);
        return !((opc == opc_lui) || (opc == opc_auipc) || (opc == opc_jal));
    endfunction

    function automatic logic reads_rs2(input logic [6:0] opc);
        case (opc)
            opc_lui, opc_auipc, opc_jal, opc_jalr, opc_load, opc_op_imm: return 1'b0;
            default: return 1'b1;               // branch, store, op and unknown
        endcase
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what);
        abort_run($sformatf("CHECK FAILED at %0t: %s", $time, what));
    endtask

    // model steps on every edge with the inputs that were driven before it
    always @(posedge id_on) begin
        logic [6:0]            opc;
        logic [log_idx_w-1:0]  rd;
        logic [log_idx_w-1:0]  rs1;
        logic [log_idx_w-1:0]  rs2;
        logic                  wr;
        logic                  fire_now;
        logic [phys_tag_w-1:0] new_tag;
        if (reset) begin
            for (int i = 0; i < num_log_regs; i++) begin
                model_map[i] = phys_tag_w'(i);
            end
            model_ready = {{(num_phys_regs - num_log_regs){1'b0}}, {num_log_regs{1'b1}}};
            free_q.delete();
            dead_q.delete();
            for (int i = num_log_regs; i < num_phys_regs; i++) begin
                free_q.push_back(phys_tag_w'(i));
            end
            model_ack = 1'b0;
        end else begin
            opc      = dat_w[6:0];
            rd       = dat_w[11:7];
            rs1      = dat_w[19:15];
            rs2      = dat_w[24:20];
            wr       = writes_dest(dat_w);
            fire_now = cyc && stb && we && !model_ack && (!wr || free_q.size() > 0);
            if (fire_now) begin
                exp_uop.opcode    = rv_opcode_e'(opc);
                exp_uop.writes_rd = wr;
                exp_uop.rd_log    = rd;
                exp_uop.rs1_tag   = model_map[rs1];
                exp_uop.rs2_tag   = model_map[rs2];
                exp_uop.rs1_ready = !reads_rs1(opc) || model_ready[model_map[rs1]]
                                    || (wb_valid && wb_tag == model_map[rs1]);
                exp_uop.rs2_ready = !reads_rs2(opc) || model_ready[model_map[rs2]]
                                    || (wb_valid && wb_tag == model_map[rs2]);
                exp_uop.old_rd_tag = model_map[rd];
                if (wr) begin
                    exp_uop.rd_tag = free_q[0];
                end
            end
            if (wb_valid) begin
                model_ready[wb_tag] = 1'b1;
            end
            if (fire_now && wr) begin
                new_tag = free_q.pop_front();
                dead_q.push_back(model_map[rd]);
                model_map[rd] = new_tag;
                model_ready[new_tag] = 1'b0;
            end
            if (rel_valid) begin
                free_q.push_back(rel_tag);
            end
            model_ack = fire_now;
        end
    end

    assert property (@(posedge id_on) disable iff (reset) ack == model_ack)
        else report_mismatch("ack");
    assert property (@(posedge id_on) disable iff (reset) uop_valid == model_ack)
        else report_mismatch("uop_valid");
    assert property (@(posedge id_on) disable iff (reset)
                     uop_valid |-> uop.opcode == exp_uop.opcode)
        else report_mismatch("opcode");
    assert property (@(posedge id_on) disable iff (reset)
                     uop_valid |-> uop.writes_rd == exp_uop.writes_rd)
        else report_mismatch("writes_rd");
    assert property (@(posedge id_on) disable iff (reset)
                     uop_valid |-> uop.rd_log == exp_uop.rd_log)
        else report_mismatch("rd_log");
    assert property (@(posedge id_on) disable iff (reset)
                     uop_valid && exp_uop.writes_rd |-> uop.rd_tag == exp_uop.rd_tag)
        else report_mismatch("rd_tag");
    assert property (@(posedge id_on) disable iff (reset)
                     uop_valid && exp_uop.writes_rd |-> uop.old_rd_tag == exp_uop.old_rd_tag)
        else report_mismatch("old_rd_tag");
    assert property (@(posedge id_on) disable iff (reset)
                     uop_valid |-> uop.rs1_tag == exp_uop.rs1_tag)
        else report_mismatch("rs1_tag");
    assert property (@(posedge id_on) disable iff (reset)
                     uop_valid |-> uop.rs1_ready == exp_uop.rs1_ready)
        else report_mismatch("rs1_ready");
    assert property (@(posedge id_on) disable iff (reset)
                     uop_valid |-> uop.rs2_tag == exp_uop.rs2_tag)
        else report_mismatch("rs2_tag");
    assert property (@(posedge id_on) disable iff (reset)
                     uop_valid |-> uop.rs2_ready == exp_uop.rs2_ready)
        else report_mismatch("rs2_ready");

    task automatic start_request(input logic [31:0] instr);
        cyc   = 1'b1;
        stb   = 1'b1;
        dat_w = instr;
    endtask

    task automatic wait_ack(output renamed_uop_t got);
        int waited;
        waited = 0;
        do begin
            @(posedge id_on);
            #1;
            waited++;
            if (!ack && waited >= ack_timeout) begin
                abort_run($sformatf("timeout: no ack within %0d cycles", ack_timeout));
            end
        end while (!ack);
        got = uop;
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    task automatic issue(input logic [31:0] instr, output renamed_uop_t got);
        start_request(instr);
        wait_ack(got);
    endtask

    task automatic release_tag(input logic [phys_tag_w-1:0] tag);
        rel_valid = 1'b1;
        rel_tag   = tag;
        @(posedge id_on);
        #1;
        rel_valid = 1'b0;
    endtask

    task automatic issue_expect(input logic [31:0] instr, input logic exp_writes,
                                input logic exp_r1, input logic exp_r2,
                                input logic [phys_tag_w-1:0] exp_rd_tag, input string what,
                                output renamed_uop_t got);
        issue(instr, got);
        assert (got.writes_rd == exp_writes) else report_mismatch({what, ": writes_rd"});
        assert (got.rs1_ready == exp_r1) else report_mismatch({what, ": rs1_ready"});
        assert (got.rs2_ready == exp_r2) else report_mismatch({what, ": rs2_ready"});
        if (exp_writes) begin
            assert (got.rd_tag == exp_rd_tag) else report_mismatch({what, ": rd_tag"});
        end
    endtask

    initial begin
        renamed_uop_t          got;
        logic [phys_tag_w-1:0] rel_order [3];
        logic [phys_tag_w-1:0] rel_first;
        logic [31:0]           instr;
        int                    alloc_rd;
        void'($urandom(17));
        id_on     = 1'b0;
        reset     = 1'b1;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b1;
        dat_w     = '0;
        wb_valid  = 1'b0;
        wb_tag    = '0;
        rel_valid = 1'b0;
        rel_tag   = '0;
        opc_table = '{opc_lui, opc_auipc, opc_jal, opc_jalr, opc_branch,
                      opc_load, opc_store, opc_op_imm, opc_op, 7'b1111111};
        repeat (5) @(posedge id_on);
        #1;
        reset = 1'b0;

        // mapping from the identity, fresh tags in order
        issue_expect(make_instr(opc_op, 5'd5, 5'd1, 5'd2), 1, 1, 1, 6'd32, "x5 write", got);
        assert (got.old_rd_tag == 6'd5) else report_mismatch("x5 old tag not 5");
        issue_expect(make_instr(opc_op, 5'd6, 5'd5, 5'd5), 1, 0, 0, 6'd33, "x5 read", got);
        assert (got.rs1_tag == 6'd32) else report_mismatch("x5 not mapped to 32");
        issue_expect(make_instr(opc_op, 5'd5, 5'd5, 5'd0), 1, 0, 1, 6'd34, "x5 rewrite", got);
        assert (got.rs1_tag == 6'd32 && got.old_rd_tag == 6'd32)
            else report_mismatch("source seen after remap");

        // writeback in the fire cycle is bypassed
        wb_valid = 1'b1;
        wb_tag   = 6'd34;
        issue_expect(make_instr(opc_op, 5'd7, 5'd5, 5'd6), 1, 1, 0, 6'd35, "bypass", got);
        wb_valid = 1'b0;
        issue_expect(make_instr(opc_op, 5'd8, 5'd5, 5'd7), 1, 1, 0, 6'd36, "written", got);

        // x7 and x6 are pending here
        issue_expect(make_instr(opc_lui, 5'd9, 5'd7, 5'd6), 1, 1, 1, 6'd37, "lui", got);
        issue_expect(make_instr(opc_auipc, 5'd10, 5'd7, 5'd6), 1, 1, 1, 6'd38, "auipc", got);
        issue_expect(make_instr(opc_jal, 5'd11, 5'd7, 5'd6), 1, 1, 1, 6'd39, "jal", got);
        issue_expect(make_instr(opc_jalr, 5'd12, 5'd7, 5'd6), 1, 0, 1, 6'd40, "jalr", got);
        issue_expect(make_instr(opc_load, 5'd13, 5'd7, 5'd6), 1, 0, 1, 6'd41, "load", got);
        issue_expect(make_instr(opc_op_imm, 5'd14, 5'd7, 5'd6), 1, 0, 1, 6'd42, "op_imm", got);
        issue_expect(make_instr(opc_branch, 5'd15, 5'd7, 5'd6), 0, 0, 0, 6'd0, "branch", got);
        issue_expect(make_instr(opc_store, 5'd15, 5'd7, 5'd6), 0, 0, 0, 6'd0, "store", got);
        issue_expect(make_instr(opc_op, 5'd0, 5'd7, 5'd6), 0, 0, 0, 6'd0, "rd x0", got);
        issue_expect(make_instr(opc_op, 5'd16, 5'd7, 5'd6), 1, 0, 0, 6'd43, "no tag used", got);

        // drain the free list
        alloc_rd = 1;
        while (free_q.size() > 0) begin
            issue(make_instr(opc_op, 5'(alloc_rd), 5'd1, 5'd2), got);
            alloc_rd = (alloc_rd % 31) + 1;
        end
        assert (got.rd_tag == 6'd63) else report_mismatch("initial tags not 32..63");

        issue(make_instr(opc_branch, 5'd3, 5'd5, 5'd6), got);
        assert (!got.writes_rd) else report_mismatch("branch writes rd");
        start_request(make_instr(opc_op, 5'd20, 5'd3, 5'd4));
        repeat (stall_cycles) begin
            @(posedge id_on);
            #1;
            assert (!ack) else report_mismatch("ack with empty free list");
        end
        rel_first = dead_q.pop_front();
        release_tag(rel_first);
        wait_ack(got);
        assert (got.rd_tag == rel_first) else report_mismatch("stalled writer missed released tag");

        // released tags come back in release order
        for (int k = 0; k < 3; k++) begin
            rel_order[k] = dead_q.pop_front();
            release_tag(rel_order[k]);
        end
        for (int k = 0; k < 3; k++) begin
            issue(make_instr(opc_op_imm, 5'(21 + k), 5'd0, 5'd0), got);
            assert (got.rd_tag == rel_order[k]) else report_mismatch("tag out of release order");
        end

        for (int n = 0; n < random_count; n++) begin
            instr = make_instr(opc_table[$urandom_range(0, 9)], 5'($urandom_range(0, 31)),
                               5'($urandom_range(0, 31)), 5'($urandom_range(0, 31)));
            if (writes_dest(instr) && free_q.size() == 0) begin
                release_tag(dead_q.pop_front());  // writer would stall otherwise
            end else if (dead_q.size() > 0 && $urandom_range(0, 3) == 0) begin
                release_tag(dead_q.pop_front());
            end
            if ($urandom_range(0, 2) == 0) begin
                wb_valid = 1'b1;
                wb_tag   = model_map[$urandom_range(0, 31)];  // live tags only
            end
            issue(instr, got);
            wb_valid = 1'b0;
        end

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
hdl/rename_pkg.sv
hdl/reg_alias_table.sv
hdl/phys_free_list.sv
hdl/rename_dispatch.sv
hdl/rename_top.sv
sim/rename_tb.sv

// File: Bender.yml
package:
  name: rename_stage

sources:
  # design, package first
  - files:
      - hdl/rename_pkg.sv
      - hdl/reg_alias_table.sv
      - hdl/phys_free_list.sv
      - hdl/rename_dispatch.sv
      - hdl/rename_top.sv

  # testbench
  - target: test
    files:
      - sim/rename_tb.sv
